/* source/dvm_scale_pkg.sv */
/*
 * Measurement arithmetic for the voltmeter
 * ADC code width, input span and calibration length
 */
`default_nettype none

package dvm_scale_pkg;

    // --------------------
    // ADC side
    // --------------------
    localparam int ad_width = 8;     // Default ADC code width, also zero code width

    // Full input span in centivolts, 2^ad_width codes cover 10.00 V
    localparam int span_cv = 1000;

    // --------------------
    // Zero-volt calibration
    // --------------------
    localparam int cal_shift = 4;    // log2 of sample count, 16 samples

endpackage

`default_nettype wire

/* source/dvm_reading_pkg.sv */
/*
 * Reading format of the voltmeter
 * One BCD digit type and the digit count of a reading
 */
`default_nettype none

package dvm_reading_pkg;

    // --------------------
    // Digits
    // --------------------
    typedef logic [3:0] bcd_digit_t;     // 0 to 9 only

    // Tens, units, tenths, hundredths
    localparam int reading_digits = 4;

    // Sign and over-range travel as plain bits
    // next to the digits, no struct here

endpackage

`default_nettype wire

/* source/voltage_calibrator.sv */
/*
 * Zero-volt calibrator
 * Sums the first 2^cal_shift samples after reset with the input
 * at 0 V and holds their average as the zero code
 */
`timescale 1ns/1ps
`default_nettype none

module voltage_calibrator
    import dvm_scale_pkg::*;
#(
    parameter int WIDTH = ad_width
) (
    input  wire              sys_clk,
    input  wire              sys_rst_n,
    input  wire              sample_en,   // One cycle per ADC sample
    input  wire  [WIDTH-1:0] ad_data,
    output logic             cal_done,    // Stays high once set
    output logic [WIDTH-1:0] zero_code    // Average code at 0 V
);

    localparam int ACC_W = WIDTH + cal_shift;

    logic [cal_shift-1:0] smp_cnt;       // Samples taken so far
    logic [ACC_W-1:0]     acc;           // Running sum
    logic [ACC_W-1:0]     acc_next;

    // Sum including the current sample
    assign acc_next = acc + ACC_W'(ad_data);

    // --------------------
    // Accumulate then freeze
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            smp_cnt   <= '0;
            acc       <= '0;
            cal_done  <= 1'b0;
            zero_code <= '0;
        end else if (sample_en && !cal_done) begin
            smp_cnt <= smp_cnt + 1'b1;
            acc     <= acc_next;
            if (&smp_cnt) begin          // Last sample of the window
                cal_done  <= 1'b1;
                // Divide by 2^cal_shift, truncated
                zero_code <= acc_next[ACC_W-1 -: WIDTH];
            end
        end
    end

endmodule

`default_nettype wire

/* source/voltage_data.sv */
/*
 * Conversion pipeline, ADC code to signed BCD reading
 * Stage 1 offset correction, stage 2 scaling to centivolts,
 * stage 3 double-dabble, one stage per sample strobe
 */
`timescale 1ns/1ps
`default_nettype none

module voltage_data
    import dvm_scale_pkg::*;
    import dvm_reading_pkg::*;
#(
    parameter int WIDTH = ad_width
) (
    input  wire              sys_clk,
    input  wire              sys_rst_n,
    input  wire              sample_en,
    input  wire              cal_done,    // Zero code is valid
    input  wire  [WIDTH-1:0] zero_code,
    input  wire  [WIDTH-1:0] ad_data,
    input  wire              ad_otr,      // Input out of range
    output logic             conv_valid,  // Reading leaves stage 3
    output logic             sign,        // 1 for negative
    output logic             over,
    output bcd_digit_t       tens,
    output bcd_digit_t       units,
    output bcd_digit_t       tenths,
    output bcd_digit_t       hundredths
);

    localparam int MAG_MAX = 10 ** reading_digits - 1;       // 9999
    localparam int MAG_W   = $clog2(10 ** reading_digits);   // Holds MAG_MAX
    localparam int BCD_W   = 4 * reading_digits;
    localparam int PROD_W  = WIDTH + $clog2(span_cv + 1);

    // Stage valid bits
    logic s1_valid, s2_valid, s3_valid;

    // Stage payload
    logic             s1_sign, s1_over;
    logic [WIDTH-1:0] s1_diff;           // Code distance from zero
    logic             s2_sign, s2_over;
    logic [MAG_W-1:0] s2_mag;            // Centivolts
    logic [PROD_W-1:0] product;
    logic [MAG_W-1:0]  scaled;
    logic              below;

    // Binary to BCD, shift and add 3
    function automatic logic [BCD_W-1:0] to_bcd(input logic [MAG_W-1:0] bin);
        logic [BCD_W-1:0] bcd;
        bcd = '0;
        for (int i = MAG_W - 1; i >= 0; i--) begin
            for (int d = 0; d < reading_digits; d++) begin
                if (bcd[4*d +: 4] > 4'd4)
                    bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
            end
            bcd = {bcd[BCD_W-2:0], bin[i]};
        end
        return bcd;
    endfunction

    assign below   = (ad_data < zero_code);
    assign product = PROD_W'(s1_diff) * PROD_W'(span_cv);
    assign scaled  = MAG_W'(product >> WIDTH);   // diff * span / 2^WIDTH

    // --------------------
    // Valid chain
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (sample_en) begin
            s1_valid <= cal_done;    // Nothing enters before calibration
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // --------------------
    // Data path
    // --------------------
    always_ff @(posedge sys_clk) begin
        if (sample_en) begin
            s1_sign <= below;        // Stage 1
            s1_diff <= below ? zero_code - ad_data : ad_data - zero_code;
            s1_over <= ad_otr;
            s2_sign <= s1_sign;      // Stage 2
            s2_over <= s1_over;
            s2_mag  <= s1_over ? MAG_W'(MAG_MAX) : scaled;
            sign    <= s2_sign;      // Stage 3
            over    <= s2_over;
            {tens, units, tenths, hundredths} <= to_bcd(s2_mag);
        end
    end

    // Result leaves stage 3 on the next strobe
    assign conv_valid = sample_en && s3_valid;

endmodule

`default_nettype wire

/* source/reading_sender.sv */
/*
 * Reading sender with credit-based flow control
 * Keeps only the newest reading, sends one per credit
 */
`timescale 1ns/1ps
`default_nettype none

module reading_sender
    import dvm_reading_pkg::*;
#(
    parameter int CREDITS = 4            // Initial credits, 1 to 15
) (
    input  wire              sys_clk,
    input  wire              sys_rst_n,
    input  wire              conv_valid,
    input  wire              sign,
    input  wire              over,
    input  wire  bcd_digit_t tens,
    input  wire  bcd_digit_t units,
    input  wire  bcd_digit_t tenths,
    input  wire  bcd_digit_t hundredths,
    input  wire              rd_credit,   // One credit back per pulse
    output logic             rd_valid,
    output logic             rd_sign,
    output logic             rd_over,
    output bcd_digit_t       rd_tens,
    output bcd_digit_t       rd_units,
    output bcd_digit_t       rd_tenths,
    output bcd_digit_t       rd_hundredths
);

    logic [3:0] credits;                 // Up to 15 outstanding
    logic       full;                    // Hold register has a reading
    logic       send;

    logic       hold_sign, hold_over;
    bcd_digit_t hold_tens, hold_units, hold_tenths, hold_hundredths;

    assign send = full && (credits != 4'd0);

    // --------------------
    // Credits and full flag
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            credits  <= 4'(CREDITS);
            full     <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            credits  <= credits + {3'b000, rd_credit} - {3'b000, send};
            rd_valid <= send;
            if (conv_valid)
                full <= 1'b1;            // Newer reading, overwrite
            else if (send)
                full <= 1'b0;
        end
    end

    // Newest reading and outgoing copy
    always_ff @(posedge sys_clk) begin
        if (conv_valid) begin
            hold_sign       <= sign;
            hold_over       <= over;
            hold_tens       <= tens;
            hold_units      <= units;
            hold_tenths     <= tenths;
            hold_hundredths <= hundredths;
        end
        if (send) begin
            rd_sign       <= hold_sign;
            rd_over       <= hold_over;
            rd_tens       <= hold_tens;
            rd_units      <= hold_units;
            rd_tenths     <= hold_tenths;
            rd_hundredths <= hold_hundredths;
        end
    end

endmodule

`default_nettype wire

/* source/test_voltage.sv */
/*
 * Test voltage generator
 * Triangle ramp 0 to 255 and back for the DAC
 */
`timescale 1ns/1ps
`default_nettype none

module test_voltage #(
    parameter int DA_STEP = 4            // sys_clk cycles per DAC step
) (
    input  wire        sys_clk,
    input  wire        sys_rst_n,
    output logic       da_clk,
    output logic [7:0] da_data
);

    localparam int HALF  = DA_STEP / 2;              // Cycles per da_clk phase
    localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic             up;                // Ramp direction

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt <= '0;
            da_clk  <= 1'b0;
            da_data <= 8'd0;
            up      <= 1'b1;
        end else if (div_cnt == CNT_W'(HALF - 1)) begin
            div_cnt <= '0;
            da_clk  <= ~da_clk;
            if (da_clk) begin            // Falling edge, step once
                if (up) begin
                    up      <= (da_data != 8'd254);  // Turn at the top
                    da_data <= da_data + 8'd1;
                end else begin
                    up      <= (da_data == 8'd1);    // Turn at zero
                    da_data <= da_data - 8'd1;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/top_dvm.sv */
/*
 * Digital voltmeter top level
 * ADC clock and sample strobe, zero-volt calibration, conversion,
 * credit-based reading port and DAC test ramp
 */
`timescale 1ns/1ps
`default_nettype none

module top_dvm
    import dvm_scale_pkg::*;
    import dvm_reading_pkg::*;
#(
    parameter int WIDTH   = ad_width,
    parameter int CREDITS = 4,
    parameter int DA_STEP = 4
) (
    input  wire              sys_clk,
    input  wire              sys_rst_n,
    input  wire  [WIDTH-1:0] ad_data,
    input  wire              ad_otr,
    input  wire              rd_credit,
    output logic             ad_clk,       // sys_clk / 2 to the ADC pin
    output logic             rd_valid,
    output logic             rd_sign,
    output logic             rd_over,
    output bcd_digit_t       rd_tens,
    output bcd_digit_t       rd_units,
    output bcd_digit_t       rd_tenths,
    output bcd_digit_t       rd_hundredths,
    output logic             cal_done,
    output logic             da_clk,
    output logic [7:0]       da_data
);

    logic             sample_en;
    logic [WIDTH-1:0] zero_code;
    logic             conv_valid;
    logic             sign, over;
    bcd_digit_t       tens, units, tenths, hundredths;

    // --------------------
    // ADC clock and strobe
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            ad_clk <= 1'b0;
        else
            ad_clk <= ~ad_clk;
    end

    assign sample_en = ~ad_clk;          // High on the cycle ad_clk rises

    voltage_calibrator #(.WIDTH(WIDTH)) u_voltage_calibrator (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .sample_en (sample_en),
        .ad_data   (ad_data),
        .cal_done  (cal_done),
        .zero_code (zero_code)
    );

    voltage_data #(.WIDTH(WIDTH)) u_voltage_data (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .sample_en  (sample_en),
        .cal_done   (cal_done),
        .zero_code  (zero_code),
        .ad_data    (ad_data),
        .ad_otr     (ad_otr),
        .conv_valid (conv_valid),
        .sign       (sign),
        .over       (over),
        .tens       (tens),
        .units      (units),
        .tenths     (tenths),
        .hundredths (hundredths)
    );

    reading_sender #(.CREDITS(CREDITS)) u_reading_sender (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .conv_valid    (conv_valid),
        .sign          (sign),
        .over          (over),
        .tens          (tens),
        .units         (units),
        .tenths        (tenths),
        .hundredths    (hundredths),
        .rd_credit     (rd_credit),
        .rd_valid      (rd_valid),
        .rd_sign       (rd_sign),
        .rd_over       (rd_over),
        .rd_tens       (rd_tens),
        .rd_units      (rd_units),
        .rd_tenths     (rd_tenths),
        .rd_hundredths (rd_hundredths)
    );

    // DAC ramp for the analog loop
    test_voltage #(.DA_STEP(DA_STEP)) u_test_voltage (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .da_clk    (da_clk),
        .da_data   (da_data)
    );

endmodule

`default_nettype wire

/* verification/dvm_asserts.sv */
/*
 * Bound checks for the voltmeter
 * Credit ledger of the reading port and the DAC triangle ramp
 */
`timescale 1ns/1ps
`default_nettype none

module dvm_asserts #(
    parameter int CREDITS = 4
) (
    input wire       sys_clk,
    input wire       sys_rst_n,
    input wire       rd_valid,
    input wire       rd_credit,
    input wire       da_clk,
    input wire [7:0] da_data
);

    int spent, returned;                 // Running ledger

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            spent    <= 0;
            returned <= 0;
        end else begin
            spent    <= spent + int'(rd_valid);
            returned <= returned + int'(rd_credit);
        end
    end

    // --------------------
    // Properties
    // --------------------
    a_credit_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        spent <= CREDITS + returned) else $error("reading sent without a credit");

    a_da_on_fall: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $changed(da_data) |-> $fell(da_clk)) else $error("DAC data moved off the fall");

    a_da_step: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $changed(da_data) |-> (8'(da_data - $past(da_data)) == 8'd1 ||
                               8'(($past(da_data)) - da_data) == 8'd1))
        else $error("DAC step is not one");

    // Turn points of the ramp
    a_da_top: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $changed(da_data) && $past(da_data) == 8'd255 |-> da_data == 8'd254)
        else $error("DAC ramp did not turn at 255");

    a_da_bottom: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $changed(da_data) && $past(da_data) == 8'd0 |-> da_data == 8'd1)
        else $error("DAC ramp did not turn at 0");

endmodule

bind top_dvm dvm_asserts #(.CREDITS(CREDITS)) u_dvm_asserts (
    .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .rd_valid(rd_valid),
    .rd_credit(rd_credit), .da_clk(da_clk), .da_data(da_data)
);

`default_nettype wire

/* verification/tb_top_dvm.sv */
/*
 * Testbench for the digital voltmeter
 * Calibrates at code 128, plays the case file through the ADC inputs,
 * returns credits with random delays and checks readings and the DAC ramp
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top_dvm
    import dvm_scale_pkg::*;
    import dvm_reading_pkg::*;
();

    localparam int n_credits = 4;
    localparam int wait_max  = 400;      // Cycles per wait loop
    localparam int da_step   = 4;
    localparam int ramp_max  = 3 * 256 * da_step;   // Full DAC period with margin

    logic             sys_clk;
    logic             sys_rst_n;
    logic [7:0]       ad_data;
    logic             ad_otr;
    logic             rd_credit = 1'b0;  // Idle before the first edge
    logic             ad_clk, rd_valid, rd_sign, rd_over, cal_done, da_clk;
    bcd_digit_t       rd_tens, rd_units, rd_tenths, rd_hundredths;
    logic [7:0]       da_data;

    int         seed = 32'h50f7_96d1;
    int         err_cnt, check_cnt, valid_cnt, credit_cnt, owed, delay_cnt;
    int         fd, n, cnt, code, otr, hold, e_sign, e_over, e_t, e_u, e_te, e_h;
    string      line;
    logic       timed_out, credit_hold, force_credit;
    logic       last_sign, last_over, prev_clk;
    bcd_digit_t last_tens, last_units, last_tenths, last_hundredths;
    logic [7:0] prev_da;
    logic       ad_clk_exp, seen_top, ramp_done;

    top_dvm #(.WIDTH(ad_width), .CREDITS(n_credits), .DA_STEP(da_step)) u_dut (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .ad_data(ad_data), .ad_otr(ad_otr),
        .rd_credit(rd_credit), .ad_clk(ad_clk), .rd_valid(rd_valid), .rd_sign(rd_sign),
        .rd_over(rd_over), .rd_tens(rd_tens), .rd_units(rd_units), .rd_tenths(rd_tenths),
        .rd_hundredths(rd_hundredths), .cal_done(cal_done), .da_clk(da_clk),
        .da_data(da_data)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;   // 8 ns period
    end

    // --------------------
    // Compare tasks
    // --------------------
    task check_reading(input string what, input bcd_digit_t got, input bcd_digit_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s digit got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task check_flag(input string what, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s got %0b expected %0b", $time, what, got, exp);
        end
    endtask

    // Whole reading against the current case row
    task compare_reading(input logic s, input logic o, input bcd_digit_t t,
                         input bcd_digit_t u, input bcd_digit_t te, input bcd_digit_t h);
        check_flag("sign", s, e_sign[0]);
        check_flag("over-range", o, e_over[0]);
        check_reading("tens", t, bcd_digit_t'(e_t));
        check_reading("units", u, bcd_digit_t'(e_u));
        check_reading("tenths", te, bcd_digit_t'(e_te));
        check_reading("hundredths", h, bcd_digit_t'(e_h));
    endtask

    // --------------------
    // Credit consumer
    // --------------------
    always @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rd_credit <= 1'b0;
            owed      <= 0;
            delay_cnt <= 0;
        end else if (force_credit) begin     // Single credit under back-pressure
            rd_credit <= 1'b1;
            owed      <= owed + int'(rd_valid) - ((owed > 0) ? 1 : 0);
        end else if (!credit_hold && owed > 0 && delay_cnt == 0) begin
            rd_credit <= 1'b1;
            owed      <= owed + int'(rd_valid) - 1;
            delay_cnt <= $random(seed) & 7;
        end else begin
            rd_credit <= 1'b0;
            owed      <= owed + int'(rd_valid);
            if (delay_cnt > 0)
                delay_cnt <= delay_cnt - 1;
        end
    end

    // Reading capture, credit ledger and DAC sampling
    always @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            valid_cnt  <= 0;
            credit_cnt <= 0;
            ad_clk_exp <= 1'b0;          // ADC clock low out of reset
            seen_top   <= 1'b0;
            ramp_done  <= 1'b0;
            prev_da    <= 8'd0;
            prev_clk   <= 1'b0;
        end else begin
            valid_cnt  <= valid_cnt + int'(rd_valid);
            credit_cnt <= credit_cnt + int'(rd_credit);
            check_flag("ADC clock", ad_clk, ad_clk_exp);
            ad_clk_exp <= ~ad_clk_exp;   // Half the system clock
            if (rd_valid) begin
                check_flag("send within credits",
                           valid_cnt + 1 <= n_credits + credit_cnt + int'(rd_credit), 1'b1);
                last_sign       <= rd_sign;
                last_over       <= rd_over;
                last_tens       <= rd_tens;
                last_units      <= rd_units;
                last_tenths     <= rd_tenths;
                last_hundredths <= rd_hundredths;
            end
            if (da_data != prev_da) begin
                check_flag("DAC step on da_clk fall", prev_clk & ~da_clk, 1'b1);
                check_flag("DAC step of one",
                           (int'(da_data) - int'(prev_da) == 1) ||
                           (int'(prev_da) - int'(da_data) == 1), 1'b1);
            end
            if (da_data == 8'd255)
                seen_top <= 1'b1;        // Top turn reached
            if (seen_top && da_data == 8'd0)
                ramp_done <= 1'b1;       // Back down at zero
            prev_da  <= da_data;
            prev_clk <= da_clk;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        err_cnt = 0;
        check_cnt = 0;
        timed_out = 1'b0;
        sys_rst_n = 1'b0;
        ad_data = 8'd128;                // 0 V during calibration
        ad_otr = 1'b0;
        credit_hold = 1'b0;
        force_credit = 1'b0;
        repeat (2) @(posedge sys_clk);
        sys_rst_n <= 1'b1;

        cnt = 0;
        while (!cal_done && cnt < wait_max) begin
            @(posedge sys_clk);
            cnt++;
        end
        if (!cal_done) begin
            timed_out = 1'b1;
            $display("Timeout: calibration did not finish");
        end

        fd = $fopen("verification/dvm_cases.txt", "r");
        if (fd == 0) begin
            timed_out = 1'b1;
            $display("Could not open the case file");
        end
        while (!timed_out && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 3 || line[0] == "#")
                continue;
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                        code, otr, hold, e_sign, e_over, e_t, e_u, e_te, e_h);
            if (n != 9)
                continue;
            if (hold > 0) begin
                ad_data <= 8'(code);
                ad_otr  <= otr[0];
                repeat (2 * hold) @(posedge sys_clk);
                compare_reading(last_sign, last_over, last_tens, last_units,
                                last_tenths, last_hundredths);
            end else begin
                // Back-pressure, use up all credits then change the code
                credit_hold <= 1'b1;
                cnt = 0;
                while (valid_cnt - credit_cnt < n_credits && cnt < wait_max) begin
                    @(posedge sys_clk);
                    cnt++;
                end
                if (valid_cnt - credit_cnt < n_credits) begin
                    timed_out = 1'b1;
                    $display("Timeout: credits were not used up under back-pressure");
                end
                ad_data <= 8'(code);
                ad_otr  <= otr[0];
                repeat (40) @(posedge sys_clk);
                force_credit <= 1'b1;
                @(posedge sys_clk);
                force_credit <= 1'b0;
                cnt = 0;
                while (!rd_valid && cnt < wait_max) begin
                    @(posedge sys_clk);
                    cnt++;
                end
                if (!rd_valid) begin
                    timed_out = 1'b1;
                    $display("Timeout: no reading after the returned credit");
                end else begin
                    compare_reading(rd_sign, rd_over, rd_tens, rd_units, rd_tenths,
                                    rd_hundredths);
                end
                credit_hold <= 1'b0;
            end
        end
        if (fd != 0)
            $fclose(fd);

        // DAC ramp through both turn points
        cnt = 0;
        while (!ramp_done && cnt < ramp_max) begin
            @(posedge sys_clk);
            cnt++;
        end
        if (!ramp_done) begin
            timed_out = 1'b1;
            $display("Timeout: DAC ramp did not run a full period");
        end

        $display("Checks: %0d  errors: %0d  readings: %0d  timeout: %0b",
                 check_cnt, err_cnt, valid_cnt, timed_out);
        if (err_cnt == 0 && !timed_out)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/dvm_cases.txt */
# code otr hold_samples | sign over tens units tenths hundredths
# hold 0 marks the back-pressure case, zero code is 128
128 0 20 0 0 0 0 0 0
153 0 20 0 0 0 0 9 7
100 0 20 1 0 0 1 0 9
255 0 20 0 0 0 4 9 6
0 0 20 1 0 0 5 0 0
200 1 20 0 1 9 9 9 9
50 1 20 1 1 9 9 9 9
129 0 20 0 0 0 0 0 3
127 0 20 1 0 0 0 0 3
64 0 20 1 0 0 2 5 0
192 0 0 0 0 0 2 5 0

/* project.f */
source/dvm_scale_pkg.sv
source/dvm_reading_pkg.sv
source/voltage_calibrator.sv
source/voltage_data.sv
source/reading_sender.sv
source/test_voltage.sv
source/top_dvm.sv
verification/dvm_asserts.sv
verification/tb_top_dvm.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the voltmeter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_top_dvm -o sim_dvm

./obj_dir/sim_dvm > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log
